// File: list.f
+incdir+verif
verilog/bev_mem_pkg.sv
verilog/bev_order_pkg.sv
verilog/order_intake.sv
verilog/order_fifo.sv
verilog/barrel_check.sv
verilog/barrel_server.sv
verilog/bev_top.sv
verif/bev_tb.sv

// File: Bender.yml
package:
  name: bev_dispenser

sources:
  - files:
      - verilog/bev_mem_pkg.sv
      - verilog/bev_order_pkg.sv
      - verilog/order_intake.sv
      - verilog/order_fifo.sv
      - verilog/barrel_check.sv
      - verilog/barrel_server.sv
      - verilog/bev_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/bev_tb.sv

// File: verif/bev_tb_model.svh
`ifndef BEV_TB_MODEL_SVH
`define BEV_TB_MODEL_SVH

// what one order should produce
typedef struct packed {
    bev_order_pkg::result_t res;
    logic                   wr;
    bev_mem_pkg::barrel_t   nb;
} expect_t;

// fibonacci form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one lfsr step per bit handed out
function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[62:0], lfsr_state[0]};
    end
    return v;
endfunction

// cup volume split by drink
function automatic bev_order_pkg::need_t recipe(input bev_order_pkg::drink_t d,
                                                input bev_order_pkg::size_t z);
    int                   tot;
    bev_order_pkg::need_t n;
    case (z)
        bev_order_pkg::l: tot = 960;
        bev_order_pkg::m: tot = 720;
        default:          tot = 480;
    endcase
    n = '0;
    case (d)
        bev_order_pkg::black_tea: n.black = 10'(tot);
        bev_order_pkg::milk_tea: begin
            n.black = 10'(tot * 3 / 4);
            n.milk  = 10'(tot / 4);
        end
        bev_order_pkg::extra_milk_tea: begin
            n.black = 10'(tot / 2);
            n.milk  = 10'(tot / 2);
        end
        bev_order_pkg::green_tea: n.green = 10'(tot);
        bev_order_pkg::green_milk_tea: begin
            n.green = 10'(tot / 2);
            n.milk  = 10'(tot / 2);
        end
        bev_order_pkg::pineapple_juice: n.pine = 10'(tot);
        bev_order_pkg::super_pineapple_tea: begin
            n.black = 10'(tot / 2);
            n.pine  = 10'(tot / 2);
        end
        default: begin
            n.black = 10'(tot / 2);
            n.milk  = 10'(tot / 4);
            n.pine  = 10'(tot / 4);
        end
    endcase
    return n;
endfunction

function automatic expect_t expected_outcome(input bev_order_pkg::order_t o,
                                             input bev_mem_pkg::barrel_t b);
    bev_order_pkg::need_t n;
    expect_t              e;
    logic                 late;
    logic                 lack;
    n    = recipe(o.drink, o.size);
    late = {o.today.month, o.today.day} > {b.month, b.day};
    lack = (int'(n.black) > int'(b.black_tea)) || (int'(n.green) > int'(b.green_tea))
        || (int'(n.milk) > int'(b.milk)) || (int'(n.pine) > int'(b.pineapple_juice));
    e.res.barrel = o.barrel;
    if (late) begin
        e.res.err = bev_order_pkg::no_exp;
    end else if (o.action == bev_order_pkg::make_drink && lack) begin
        e.res.err = bev_order_pkg::no_ing;
    end else begin
        e.res.err = bev_order_pkg::no_err;
    end
    e.wr = (o.action == bev_order_pkg::make_drink) && (e.res.err == bev_order_pkg::no_err);
    e.nb = b;
    if (e.wr) begin
        e.nb.black_tea       = b.black_tea - 12'(n.black);
        e.nb.green_tea       = b.green_tea - 12'(n.green);
        e.nb.milk            = b.milk - 12'(n.milk);
        e.nb.pineapple_juice = b.pineapple_juice - 12'(n.pine);
    end
    return e;
endfunction

`endif

// File: verif/bev_tb.sv
`default_nettype none

module bev_tb;

    localparam int clk_period = 8;
    localparam int wait_limit = 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   order_valid;
    bev_order_pkg::order_t  order;
    logic                   order_ready;
    bev_mem_pkg::mem_req_t  mem_req;
    bev_mem_pkg::mem_rsp_t  mem_rsp;
    logic                   result_valid;
    bev_order_pkg::result_t result;

    logic [31:0]            lfsr_state;
    bev_mem_pkg::barrel_t   storage [256];
    bev_mem_pkg::barrel_t   shadow [256];
    bev_order_pkg::order_t  pending [$];
    int                     accepted;
    int                     results_seen;
    int                     writes_seen;
    int                     writes_expected;
    int                     value_errors;
    int                     other_errors;
    logic                   saw_stall;

    `include "bev_tb_model.svh"

    bev_top #(
        .ORDER_DEPTH (4)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .order_valid  (order_valid),
        .order        (order),
        .order_ready  (order_ready),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ========================================================================
    // storage model, one request at a time
    // ========================================================================

    initial begin : storage_model
        bev_mem_pkg::mem_req_t req;
        int                    delay;
        mem_rsp = '0;
        forever begin
            @(posedge clk);
            if (mem_req.valid) begin
                req   = mem_req;
                delay = int'(take_bits(2)) + 1;
                if (!req.read) begin
                    storage[req.addr] = req.wdata;
                    writes_seen++;
                end
                repeat (delay - 1) @(posedge clk);
                #1;
                mem_rsp.valid = 1'b1;
                mem_rsp.rdata = storage[req.addr];
                @(posedge clk);
                #1;
                mem_rsp = '0;
            end
        end
    end

    // ========================================================================
    // result compare
    // ========================================================================

    initial begin : compare_results
        bev_order_pkg::order_t o;
        expect_t               e;
        forever begin
            @(posedge clk);
            if (result_valid) begin
                if (pending.size() == 0) begin
                    other_errors++;
                    $display("a result arrived while no order was pending");
                end else begin
                    o = pending.pop_front();
                    e = expected_outcome(o, shadow[o.barrel]);
                    if (result !== e.res) begin
                        value_errors++;
                        $display("** Error: result = %h, expected %h", result, e.res);
                    end
                    if (e.wr) begin
                        shadow[o.barrel] = e.nb;
                        writes_expected++;
                        if (storage[o.barrel] !== e.nb) begin
                            value_errors++;
                            $display("** Error: storage[%h] = %h, expected %h",
                                     o.barrel, storage[o.barrel], e.nb);
                        end
                    end
                    if (writes_seen != writes_expected) begin
                        value_errors++;
                        $display("** Error: write count = %h, expected %h",
                                 writes_seen, writes_expected);
                    end
                end
                results_seen++;
            end
        end
    end

    // ========================================================================
    // stimulus helpers
    // ========================================================================

    function automatic bev_order_pkg::size_t size_of(input int i);
        case (i)
            0:       return bev_order_pkg::l;
            1:       return bev_order_pkg::m;
            default: return bev_order_pkg::s;
        endcase
    endfunction

    function automatic bev_order_pkg::order_t build_order(input bev_order_pkg::action_t a,
                                                          input int d, input int z,
                                                          input int mon, input int day,
                                                          input int bar);
        bev_order_pkg::order_t o;
        o.action      = a;
        o.drink       = bev_order_pkg::drink_t'(3'(d));
        o.size        = size_of(z);
        o.today.month = 4'(mon);
        o.today.day   = 5'(day);
        o.barrel      = 8'(bar);
        return o;
    endfunction

    function automatic bev_order_pkg::order_t random_order();
        bev_order_pkg::action_t a;
        int                     d;
        int                     z;
        int                     mon;
        int                     day;
        a   = (take_bits(1) != 0) ? bev_order_pkg::check_date : bev_order_pkg::make_drink;
        d   = int'(take_bits(3));
        z   = int'(take_bits(2)) % 3;
        mon = int'(take_bits(4));
        day = int'(take_bits(5));
        return build_order(a, d, z, mon, day, int'(take_bits(8)));
    endfunction

    // same word into storage and the expected copy
    task automatic load_barrel(input int bar, input int vol, input int mon, input int day);
        bev_mem_pkg::barrel_t b;
        b                 = '0;
        b.black_tea       = 12'(vol);
        b.green_tea       = 12'(vol);
        b.milk            = 12'(vol);
        b.pineapple_juice = 12'(vol);
        b.month           = 4'(mon);
        b.day             = 5'(day);
        storage[bar]      = b;
        shadow[bar]       = b;
    endtask

    // holds the order until the edge that accepts it
    task automatic send_order(input bev_order_pkg::order_t o);
        int waited;
        waited = 0;
        #1;
        order_valid = 1'b1;
        order       = o;
        @(posedge clk);
        while (!order_ready && waited < wait_limit) begin
            waited++;
            @(posedge clk);
        end
        if (order_ready) begin
            pending.push_back(o);
            accepted++;
        end else begin
            other_errors++;
            $display("timed out waiting for order_ready");
        end
        if (waited > 0) begin
            saw_stall = 1'b1;
        end
    endtask

    task automatic release_bus();
        #1;
        order_valid = 1'b0;
    endtask

    task automatic wait_results();
        int waited;
        waited = 0;
        while (results_seen != accepted && waited < wait_limit) begin
            waited++;
            @(posedge clk);
        end
        if (results_seen != accepted) begin
            other_errors++;
            $display("timed out waiting for results, %0d of %0d arrived",
                     results_seen, accepted);
        end
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================

    initial begin : main
        rst_n           = 1'b0;
        order_valid     = 1'b0;
        order           = '0;
        accepted        = 0;
        results_seen    = 0;
        writes_seen     = 0;
        writes_expected = 0;
        value_errors    = 0;
        other_errors    = 0;
        saw_stall       = 1'b0;
        lfsr_state      = 32'h62af;
        for (int i = 0; i < 256; i++) begin
            storage[i] = take_bits(64);
            shadow[i]  = storage[i];
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);

        // idle outputs after reset
        if (result_valid !== 1'b0) begin
            value_errors++;
            $display("** Error: result_valid = %h, expected %h", result_valid, 1'b0);
        end
        if (mem_req.valid !== 1'b0) begin
            value_errors++;
            $display("** Error: mem_req.valid = %h, expected %h", mem_req.valid, 1'b0);
        end
        if (order_ready !== 1'b1) begin
            value_errors++;
            $display("** Error: order_ready = %h, expected %h", order_ready, 1'b1);
        end

        // date check around june 15
        load_barrel(10, 2000, 6, 15);
        send_order(build_order(bev_order_pkg::check_date, 0, 0, 6, 14, 10));
        send_order(build_order(bev_order_pkg::check_date, 0, 0, 6, 15, 10));
        send_order(build_order(bev_order_pkg::check_date, 0, 0, 6, 16, 10));
        send_order(build_order(bev_order_pkg::check_date, 0, 0, 7, 1, 10));
        release_bus();
        wait_results();

        // every drink and size on its own full barrel
        for (int d = 0; d < 8; d++) begin
            for (int z = 0; z < 3; z++) begin
                load_barrel(32 + d * 3 + z, 4095, 12, 31);
                send_order(build_order(bev_order_pkg::make_drink, d, z, 1, 1, 32 + d * 3 + z));
            end
        end
        release_bus();
        wait_results();

        // expired and empty, then in date but short
        load_barrel(60, 0, 3, 3);
        load_barrel(61, 100, 12, 31);
        send_order(build_order(bev_order_pkg::make_drink, 7, 0, 4, 1, 60));
        send_order(build_order(bev_order_pkg::make_drink, 0, 0, 4, 1, 61));
        send_order(build_order(bev_order_pkg::check_date, 0, 0, 4, 1, 61));
        release_bus();
        wait_results();

        // stock carries over between orders
        load_barrel(70, 2000, 9, 9);
        repeat (3) begin
            send_order(build_order(bev_order_pkg::make_drink, 0, 0, 9, 9, 70));
        end
        release_bus();
        wait_results();

        saw_stall = 1'b0;
        repeat (12) begin
            send_order(random_order());
        end
        release_bus();
        wait_results();
        if (!saw_stall) begin
            other_errors++;
            $display("order_ready never dropped during the burst");
        end

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/bev_top.sv
`default_nettype none

module bev_top #(
    parameter int ORDER_DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   order_valid,
    input  bev_order_pkg::order_t  order,
    output logic                   order_ready,
    output bev_mem_pkg::mem_req_t  mem_req,
    input  bev_mem_pkg::mem_rsp_t  mem_rsp,
    output logic                   result_valid,
    output bev_order_pkg::result_t result
);

    logic                job_valid;
    bev_order_pkg::job_t job;
    logic                credit_return;
    logic                job_avail;
    bev_order_pkg::job_t head;
    logic                job_pop;

    // producer, spends credits
    order_intake #(
        .DEPTH (ORDER_DEPTH)
    ) u_intake (
        .clk           (clk),
        .rst_n         (rst_n),
        .order_valid   (order_valid),
        .order         (order),
        .order_ready   (order_ready),
        .credit_return (credit_return),
        .job_valid     (job_valid),
        .job           (job)
    );

    order_fifo #(
        .DEPTH (ORDER_DEPTH)
    ) u_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .job_valid     (job_valid),
        .job           (job),
        .job_pop       (job_pop),
        .job_avail     (job_avail),
        .head          (head),
        .credit_return (credit_return)
    );

    // consumer, talks to storage
    barrel_server u_server (
        .clk          (clk),
        .rst_n        (rst_n),
        .job_avail    (job_avail),
        .head         (head),
        .job_pop      (job_pop),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: verilog/barrel_server.sv
`default_nettype none

module barrel_server (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   job_avail,
    input  bev_order_pkg::job_t    head,
    output logic                   job_pop,
    output bev_mem_pkg::mem_req_t  mem_req,
    input  bev_mem_pkg::mem_rsp_t  mem_rsp,
    output logic                   result_valid,
    output bev_order_pkg::result_t result
);

    typedef enum logic [2:0] {
        idle,
        read_wait,
        compare,
        write_wait,
        report
    } state_t;

    state_t                state;
    logic                  req_valid;
    bev_order_pkg::job_t   job_q;
    bev_mem_pkg::barrel_t  stored_q;
    bev_mem_pkg::barrel_t  updated;
    bev_order_pkg::err_t   err;
    bev_order_pkg::err_t   err_q;
    logic                  expired;
    logic                  short;
    logic                  do_write;

    barrel_check u_check (
        .job     (job_q),
        .stored  (stored_q),
        .expired (expired),
        .short   (short),
        .updated (updated)
    );

    // ========================================================================
    // decision
    // ========================================================================

    // expiry wins, stock only counts when a drink is made
    always_comb begin
        if (expired) begin
            err = bev_order_pkg::no_exp;
        end else if (job_q.action == bev_order_pkg::make_drink && short) begin
            err = bev_order_pkg::no_ing;
        end else begin
            err = bev_order_pkg::no_err;
        end
    end

    assign do_write = (job_q.action == bev_order_pkg::make_drink)
                    & (err == bev_order_pkg::no_err);

    // ========================================================================
    // FSM, one job at a time
    // ========================================================================

    assign job_pop = (state == idle) & job_avail;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            req_valid <= 1'b0;
        end else begin
            req_valid <= 1'b0;
            case (state)
                idle: begin
                    if (job_avail) begin
                        state     <= read_wait;
                        req_valid <= 1'b1;
                    end
                end
                read_wait: begin
                    if (mem_rsp.valid) begin
                        state <= compare;
                    end
                end
                compare: begin
                    if (do_write) begin
                        state     <= write_wait;
                        req_valid <= 1'b1;
                    end else begin
                        state <= report;
                    end
                end
                // response here is the write ack
                write_wait: begin
                    if (mem_rsp.valid) begin
                        state <= report;
                    end
                end
                report:  state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (job_pop) begin
            job_q <= head;
        end
        if (state == read_wait && mem_rsp.valid) begin
            stored_q <= mem_rsp.rdata;
        end
        if (state == compare) begin
            err_q <= err;
        end
    end

    // address and data are held by job_q and stored_q while waiting
    assign mem_req = '{
        valid: req_valid,
        read:  (state == read_wait),
        addr:  job_q.barrel,
        wdata: updated
    };

    assign result_valid = (state == report);
    assign result       = '{err: err_q, barrel: job_q.barrel};

endmodule

`default_nettype wire

// File: verilog/barrel_check.sv
`default_nettype none

module barrel_check (
    input  bev_order_pkg::job_t  job,
    input  bev_mem_pkg::barrel_t stored,
    output logic                 expired,
    output logic                 short,
    output bev_mem_pkg::barrel_t updated
);

    localparam int pad_w = bev_mem_pkg::vol_w - bev_order_pkg::need_w;

    bev_mem_pkg::date_t            stored_date;
    logic [bev_mem_pkg::vol_w-1:0] need_black;
    logic [bev_mem_pkg::vol_w-1:0] need_green;
    logic [bev_mem_pkg::vol_w-1:0] need_milk;
    logic [bev_mem_pkg::vol_w-1:0] need_pine;

    assign stored_date = '{month: stored.month, day: stored.day};

    // month then day, so a plain compare orders the dates
    assign expired = (job.today > stored_date);

    // needs widened to the stored volume width
    assign need_black = {{pad_w{1'b0}}, job.need.black};
    assign need_green = {{pad_w{1'b0}}, job.need.green};
    assign need_milk  = {{pad_w{1'b0}}, job.need.milk};
    assign need_pine  = {{pad_w{1'b0}}, job.need.pine};

    assign short = (need_black > stored.black_tea)
                 | (need_green > stored.green_tea)
                 | (need_milk  > stored.milk)
                 | (need_pine  > stored.pineapple_juice);

    // only meaningful when nothing is short
    always_comb begin
        updated                 = stored;
        updated.black_tea       = stored.black_tea - need_black;
        updated.green_tea       = stored.green_tea - need_green;
        updated.milk            = stored.milk - need_milk;
        updated.pineapple_juice = stored.pineapple_juice - need_pine;
    end

endmodule

`default_nettype wire

// File: verilog/order_fifo.sv
`default_nettype none

module order_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                job_valid,
    input  bev_order_pkg::job_t job,
    input  logic                job_pop,
    output logic                job_avail,
    output bev_order_pkg::job_t head,
    output logic                credit_return
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    bev_order_pkg::job_t mem [DEPTH];
    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    logic [cnt_w-1:0]    count;
    logic                pop;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign job_avail = (count != '0);
    assign pop       = job_pop & job_avail;
    assign head      = mem[rd_ptr];

    // no full check, the intake never pushes without a credit
    always_ff @(posedge clk) begin
        if (job_valid) begin
            mem[wr_ptr] <= job;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (job_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({job_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= pop;
        end
    end

endmodule

`default_nettype wire

// File: verilog/order_intake.sv
`default_nettype none

module order_intake #(
    parameter int DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  order_valid,
    input  bev_order_pkg::order_t order,
    output logic                  order_ready,
    input  logic                  credit_return,
    output logic                  job_valid,
    output bev_order_pkg::job_t   job
);

    localparam int cnt_w = $clog2(DEPTH + 1);

    logic [cnt_w-1:0]                 credits;
    logic                             accept;
    logic [bev_order_pkg::need_w-1:0] q1;
    logic [bev_order_pkg::need_w-1:0] q2;
    logic [bev_order_pkg::need_w-1:0] q3;
    logic [bev_order_pkg::need_w-1:0] q4;
    bev_order_pkg::need_t             need;

    // ========================================================================
    // credits, one per free buffer slot
    // ========================================================================

    assign order_ready = (credits != '0);
    assign accept      = order_valid & order_ready;

    // spent at accept so the job in flight already owns its slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= cnt_w'(DEPTH);
        end else begin
            case ({accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // ========================================================================
    // recipe lookup
    // ========================================================================

    // every recipe is whole quarters of the cup
    always_comb begin
        case (order.size)
            bev_order_pkg::l: q1 = 10'd240;
            bev_order_pkg::m: q1 = 10'd180;
            bev_order_pkg::s: q1 = 10'd120;
            default:          q1 = '0;
        endcase
    end

    assign q2 = q1 << 1;
    assign q3 = q1 + q2;
    assign q4 = q1 << 2;

    always_comb begin
        need = '0;
        case (order.drink)
            bev_order_pkg::black_tea:       need.black = q4;
            bev_order_pkg::green_tea:       need.green = q4;
            bev_order_pkg::pineapple_juice: need.pine = q4;
            bev_order_pkg::milk_tea: begin
                need.black = q3;
                need.milk  = q1;
            end
            bev_order_pkg::extra_milk_tea: begin
                need.black = q2;
                need.milk  = q2;
            end
            bev_order_pkg::green_milk_tea: begin
                need.green = q2;
                need.milk  = q2;
            end
            bev_order_pkg::super_pineapple_tea: begin
                need.black = q2;
                need.pine  = q2;
            end
            bev_order_pkg::super_pineapple_milk_tea: begin
                need.black = q2;
                need.milk  = q1;
                need.pine  = q1;
            end
            default: need = '0;
        endcase
    end

    // ========================================================================
    // job register
    // ========================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            job_valid <= 1'b0;
        end else begin
            job_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            job.action <= order.action;
            job.today  <= order.today;
            job.barrel <= order.barrel;
            job.need   <= need;
        end
    end

endmodule

`default_nettype wire

// File: verilog/bev_order_pkg.sv
`default_nettype none

// order side types, from intake down to the result port
package bev_order_pkg;

    // supply code 2'd1 is left unused
    typedef enum logic [1:0] {
        make_drink = 2'd0,
        check_date = 2'd2
    } action_t;

    typedef enum logic [2:0] {
        black_tea,
        milk_tea,
        extra_milk_tea,
        green_tea,
        green_milk_tea,
        pineapple_juice,
        super_pineapple_tea,
        super_pineapple_milk_tea
    } drink_t;

    typedef enum logic [1:0] {
        l = 2'b00,
        m = 2'b01,
        s = 2'b11
    } size_t;

    typedef enum logic [1:0] {
        no_err = 2'd0,
        no_exp = 2'd1,
        no_ing = 2'd2
    } err_t;

    localparam int need_w = 10;

    // required volume per ingredient
    typedef struct packed {
        logic [need_w-1:0] black;
        logic [need_w-1:0] green;
        logic [need_w-1:0] milk;
        logic [need_w-1:0] pine;
    } need_t;

    typedef struct packed {
        action_t                            action;
        drink_t                             drink;
        size_t                              size;
        bev_mem_pkg::date_t                 today;
        logic [bev_mem_pkg::mem_addr_w-1:0] barrel;
    } order_t;

    typedef struct packed {
        action_t                            action;
        bev_mem_pkg::date_t                 today;
        logic [bev_mem_pkg::mem_addr_w-1:0] barrel;
        need_t                              need;
    } job_t;

    typedef struct packed {
        err_t                               err;
        logic [bev_mem_pkg::mem_addr_w-1:0] barrel;
    } result_t;

endpackage

`default_nettype wire

// File: verilog/bev_mem_pkg.sv
`default_nettype none

// storage side layout, shared by the barrel server and the storage model
package bev_mem_pkg;

    localparam int mem_data_w = 64;
    localparam int mem_addr_w = 8;
    localparam int vol_w      = 12;
    localparam int month_w    = 4;
    localparam int day_w      = 5;

    // month above day so the packed value orders like a calendar
    typedef struct packed {
        logic [month_w-1:0] month;
        logic [day_w-1:0]   day;
    } date_t;

    // one barrel as it sits in storage, msb first
    typedef struct packed {
        logic [vol_w-1:0]   black_tea;
        logic [vol_w-1:0]   green_tea;
        logic [3:0]         pad_hi;
        logic [month_w-1:0] month;
        logic [vol_w-1:0]   milk;
        logic [vol_w-1:0]   pineapple_juice;
        logic [2:0]         pad_lo;
        logic [day_w-1:0]   day;
    } barrel_t;

    typedef struct packed {
        logic                  valid;
        logic                  read;
        logic [mem_addr_w-1:0] addr;
        logic [mem_data_w-1:0] wdata;
    } mem_req_t;

    // valid doubles as the write acknowledge
    typedef struct packed {
        logic                  valid;
        logic [mem_data_w-1:0] rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire
